// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int xlen = 64;           // Register and address width

    localparam logic [4:0] reg_ra = 5'd31;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Primary opcodes, inst[31:26]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_daddiu  = 6'h19;
    localparam logic [5:0] op_ld      = 6'h37;
    localparam logic [5:0] op_sd      = 6'h3f;

    // Function codes under op_special, inst[5:0]
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_break   = 6'h0d;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_slt     = 6'h2a;
    localparam logic [5:0] fn_daddu   = 6'h2d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode enums, the zero value of each is what a bubble carries
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_sll = 3'd5
    } alu_op_t;

    typedef enum logic [2:0] {
        ctl_none      = 3'd0,
        ctl_branch_eq = 3'd1,
        ctl_branch_ne = 3'd2,
        ctl_jump      = 3'd3,
        ctl_jump_link = 3'd4
    } control_type_t;

    typedef enum logic [1:0] {
        mem_none         = 2'd0,
        mem_load_double  = 2'd1,
        mem_store_double = 2'd2
    } mem_type_t;

    typedef enum logic [1:0] {b_reg = 2'd0, b_sext_imm = 2'd1, b_zext_imm = 2'd2} alu_b_src_t;

    typedef enum logic [1:0] {rd_from_rd = 2'd0, rd_from_rt = 2'd1, rd_from_ra = 2'd2} rd_src_t;

endpackage

`default_nettype wire

// File: verilog/mips_decoder.sv
`default_nettype none

module mips_decoder (
    input  logic [31:0]               inst,
    output mips_pkg::alu_op_t         alu_op,
    output mips_pkg::control_type_t   control_type,
    output mips_pkg::mem_type_t       mem_type,
    output mips_pkg::alu_b_src_t      alu_b_src,
    output mips_pkg::rd_src_t         rd_src,
    output logic                      write_enable,
    output logic                      lui,
    output logic                      b_is_reg,
    output logic                      syscall,
    output logic                      break_inst,
    output logic                      reserved,
    output logic [4:0]                rs,
    output logic [4:0]                rt,
    output logic [4:0]                rd,
    output logic [4:0]                shamt
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign shamt  = inst[10:6];
    assign funct  = inst[5:0];

    always_comb begin
        alu_op       = alu_add;
        control_type = ctl_none;
        mem_type     = mem_none;
        alu_b_src    = b_reg;
        rd_src       = rd_from_rd;
        write_enable = 1'b0;
        lui          = 1'b0;
        b_is_reg     = 1'b0;
        syscall      = 1'b0;
        break_inst   = 1'b0;
        reserved     = 1'b0;

        case (opcode)
            op_special: begin
                // ALU forms read rt and write rd, the traps undo this below
                write_enable = 1'b1;
                b_is_reg     = 1'b1;
                case (funct)
                    fn_addu, fn_daddu: alu_op = alu_add;
                    fn_subu:           alu_op = alu_sub;
                    fn_and:            alu_op = alu_and;
                    fn_or:             alu_op = alu_or;
                    fn_slt:            alu_op = alu_slt;
                    fn_sll:            alu_op = alu_sll;    // Shift amount comes from shamt
                    fn_syscall: begin
                        write_enable = 1'b0;
                        b_is_reg     = 1'b0;
                        syscall      = 1'b1;
                    end
                    fn_break: begin
                        write_enable = 1'b0;
                        b_is_reg     = 1'b0;
                        break_inst   = 1'b1;
                    end
                    default: begin
                        write_enable = 1'b0;
                        b_is_reg     = 1'b0;
                        reserved     = 1'b1;
                    end
                endcase
            end
            op_addiu, op_daddiu: begin
                alu_b_src    = b_sext_imm;
                rd_src       = rd_from_rt;
                write_enable = 1'b1;
            end
            op_ori: begin
                alu_op       = alu_or;
                alu_b_src    = b_zext_imm;
                rd_src       = rd_from_rt;
                write_enable = 1'b1;
            end
            op_lui: begin
                // EX places the immediate in the upper half when lui is set
                alu_op       = alu_or;
                alu_b_src    = b_zext_imm;
                rd_src       = rd_from_rt;
                write_enable = 1'b1;
                lui          = 1'b1;
            end
            op_ld: begin
                alu_b_src    = b_sext_imm;
                mem_type     = mem_load_double;
                rd_src       = rd_from_rt;
                write_enable = 1'b1;
            end
            op_sd: begin
                alu_b_src = b_sext_imm;
                mem_type  = mem_store_double;
                b_is_reg  = 1'b1;                   // Store data is rt
            end
            op_beq: begin
                alu_op       = alu_sub;
                control_type = ctl_branch_eq;
                b_is_reg     = 1'b1;
            end
            op_bne: begin
                alu_op       = alu_sub;
                control_type = ctl_branch_ne;
                b_is_reg     = 1'b1;
            end
            op_j:   control_type = ctl_jump;
            op_jal: begin
                control_type = ctl_jump_link;
                rd_src       = rd_from_ra;
                write_enable = 1'b1;
            end
            default: reserved = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`default_nettype none

module regfile #(
    parameter int data_width = 64
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [4:0]            rs_num,
    input  logic [4:0]            rt_num,
    output logic [data_width-1:0] rs_data,
    output logic [data_width-1:0] rt_data,
    input  logic                  write_enable,
    input  logic [4:0]            w_num,
    input  logic [data_width-1:0] w_data
);

    logic [data_width-1:0] regs [32];
    logic                  write_live;
    logic                  rs_bypass;
    logic                  rt_bypass;

    assign write_live = write_enable && (w_num != 5'd0);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_live) begin
            regs[w_num] <= w_data;
        end
    end

    // Same-cycle writeback is visible to the reader
    assign rs_bypass = write_live && (w_num == rs_num);
    assign rt_bypass = write_live && (w_num == rt_num);

    assign rs_data = rs_bypass ? w_data : regs[rs_num];
    assign rt_data = rt_bypass ? w_data : regs[rt_num];

endmodule

`default_nettype wire

// File: verilog/load_use_hazard.sv
`default_nettype none

module load_use_hazard (
    input  logic       ex_mem_read,
    input  logic [4:0] ex_w_regnum,
    input  logic [4:0] rs_num,
    input  logic [4:0] rt_num,
    input  logic       b_is_reg,
    output logic       stall
);

    logic load_in_ex;
    logic rs_match;
    logic rt_match;

    // A load into register 0 never produces a value anyone waits for
    assign load_in_ex = ex_mem_read && (ex_w_regnum != 5'd0);

    assign rs_match = (ex_w_regnum == rs_num);
    assign rt_match = b_is_reg && (ex_w_regnum == rt_num);   // rt only counts when it is read

    assign stall = load_in_ex && (rs_match || rt_match);

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter int data_width = 64
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [31:0]             inst,
    input  logic [data_width-1:0]   pc,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    wb_write_enable,
    input  logic [4:0]              wb_regnum,
    input  logic [data_width-1:0]   wb_data,
    output logic [4:0]              rs_num,
    output logic [4:0]              rt_num,
    output logic                    b_is_reg,
    output mips_pkg::alu_op_t       id_alu_op,
    output mips_pkg::control_type_t id_control_type,
    output mips_pkg::mem_type_t     id_mem_type,
    output mips_pkg::alu_b_src_t    id_alu_b_src,
    output logic                    id_write_enable,
    output logic                    id_lui,
    output logic                    id_syscall,
    output logic                    id_break,
    output logic                    id_reserved,
    output logic [4:0]              id_w_regnum,
    output logic [4:0]              id_shamt,
    output logic [data_width-1:0]   id_a_data,
    output logic [data_width-1:0]   id_b_data,
    output logic [31:0]             id_inst,
    output logic [data_width-1:0]   id_pc,
    output logic [data_width-1:0]   id_pc4,
    output logic [data_width-1:0]   id_pc_branch,
    output logic [data_width-1:0]   id_jump_addr
);
    import mips_pkg::*;

    alu_op_t               alu_op;
    control_type_t         control_type;
    mem_type_t             mem_type;
    alu_b_src_t            alu_b_src;
    rd_src_t               rd_src;
    logic                  write_enable, lui, syscall, break_inst, reserved;
    logic [4:0]            rd, shamt, w_regnum;
    logic [data_width-1:0] rs_data, rt_data, b_data;
    logic [data_width-1:0] pc4, pc_branch, jump_addr;
    logic                  bubble;

    mips_decoder i_mips_decoder (
        .inst        (inst),
        .alu_op      (alu_op),
        .control_type(control_type),
        .mem_type    (mem_type),
        .alu_b_src   (alu_b_src),
        .rd_src      (rd_src),
        .write_enable(write_enable),
        .lui         (lui),
        .b_is_reg    (b_is_reg),
        .syscall     (syscall),
        .break_inst  (break_inst),
        .reserved    (reserved),
        .rs          (rs_num),
        .rt          (rt_num),
        .rd          (rd),
        .shamt       (shamt)
    );

    regfile #(.data_width(data_width)) i_regfile (
        .clock       (clock),
        .reset       (reset),
        .rs_num      (rs_num),
        .rt_num      (rt_num),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .write_enable(wb_write_enable),
        .w_num       (wb_regnum),
        .w_data      (wb_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Addresses, destination and operand B
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pc4       = pc + data_width'(4);
    assign pc_branch = pc4 + {{(data_width - 18){inst[15]}}, inst[15:0], 2'b00};
    assign jump_addr = {pc[data_width-1:28], inst[25:0], 2'b00};   // Stays in the 256 MB region

    always_comb begin
        case (rd_src)
            rd_from_rt: w_regnum = rt_num;
            rd_from_ra: w_regnum = reg_ra;
            default:    w_regnum = rd;
        endcase
    end

    // Exception handling wants the faulting word, so it rides in place of rt
    assign b_data = (syscall || break_inst || reserved) ?
                    {{(data_width - 32){1'b0}}, inst} : rt_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ID/EX register, a load-use stall becomes a bubble rather than a hold
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign bubble = stall || flush;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            id_alu_op       <= alu_add;
            id_control_type <= ctl_none;
            id_mem_type     <= mem_none;
            id_alu_b_src    <= b_reg;
            id_write_enable <= 1'b0;
            id_lui          <= 1'b0;
            id_syscall      <= 1'b0;
            id_break        <= 1'b0;
            id_reserved     <= 1'b0;
            id_w_regnum     <= '0;
            id_shamt        <= '0;
            id_a_data       <= '0;
            id_b_data       <= '0;
            id_inst         <= '0;
            id_pc           <= '0;
            id_pc4          <= '0;
            id_pc_branch    <= '0;
            id_jump_addr    <= '0;
        end else begin
            id_alu_op       <= bubble ? alu_add : alu_op;
            id_control_type <= bubble ? ctl_none : control_type;
            id_mem_type     <= bubble ? mem_none : mem_type;
            id_alu_b_src    <= bubble ? b_reg : alu_b_src;
            id_write_enable <= !bubble && write_enable;
            id_lui          <= !bubble && lui;
            id_syscall      <= !bubble && syscall;
            id_break        <= !bubble && break_inst;
            id_reserved     <= !bubble && reserved;
            id_w_regnum     <= bubble ? 5'd0 : w_regnum;
            id_shamt        <= bubble ? 5'd0 : shamt;
            id_a_data       <= bubble ? '0 : rs_data;
            id_b_data       <= bubble ? '0 : b_data;
            id_inst         <= bubble ? '0 : inst;
            id_pc4          <= bubble ? '0 : pc4;
            id_pc_branch    <= bubble ? '0 : pc_branch;
            id_jump_addr    <= bubble ? '0 : jump_addr;
            id_pc           <= pc;                  // EPC source, loads even in a bubble
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_top.sv
`default_nettype none

module decode_top #(
    parameter int data_width = mips_pkg::xlen
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [31:0]             inst,
    input  logic [data_width-1:0]   pc,
    input  logic                    flush,
    input  logic                    ex_mem_read,
    input  logic [4:0]              ex_w_regnum,
    input  logic                    wb_write_enable,
    input  logic [4:0]              wb_regnum,
    input  logic [data_width-1:0]   wb_data,
    output logic                    stall,
    output mips_pkg::alu_op_t       id_alu_op,
    output mips_pkg::control_type_t id_control_type,
    output mips_pkg::mem_type_t     id_mem_type,
    output mips_pkg::alu_b_src_t    id_alu_b_src,
    output logic                    id_write_enable,
    output logic                    id_lui,
    output logic                    id_syscall,
    output logic                    id_break,
    output logic                    id_reserved,
    output logic [4:0]              id_w_regnum,
    output logic [4:0]              id_shamt,
    output logic [data_width-1:0]   id_a_data,
    output logic [data_width-1:0]   id_b_data,
    output logic [31:0]             id_inst,
    output logic [data_width-1:0]   id_pc,
    output logic [data_width-1:0]   id_pc4,
    output logic [data_width-1:0]   id_pc_branch,
    output logic [data_width-1:0]   id_jump_addr
);

    logic [4:0] rs_num;
    logic [4:0] rt_num;
    logic       b_is_reg;

    decode_stage #(.data_width(data_width)) i_decode_stage (
        .clock(clock), .reset(reset), .inst(inst), .pc(pc),
        .stall(stall), .flush(flush),
        .wb_write_enable(wb_write_enable), .wb_regnum(wb_regnum), .wb_data(wb_data),
        .rs_num(rs_num), .rt_num(rt_num), .b_is_reg(b_is_reg),
        .id_alu_op(id_alu_op), .id_control_type(id_control_type),
        .id_mem_type(id_mem_type), .id_alu_b_src(id_alu_b_src),
        .id_write_enable(id_write_enable), .id_lui(id_lui),
        .id_syscall(id_syscall), .id_break(id_break), .id_reserved(id_reserved),
        .id_w_regnum(id_w_regnum), .id_shamt(id_shamt),
        .id_a_data(id_a_data), .id_b_data(id_b_data), .id_inst(id_inst),
        .id_pc(id_pc), .id_pc4(id_pc4),
        .id_pc_branch(id_pc_branch), .id_jump_addr(id_jump_addr)
    );

    // Compares against the instruction in EX, stall goes back to fetch too
    load_use_hazard i_load_use_hazard (
        .ex_mem_read(ex_mem_read),
        .ex_w_regnum(ex_w_regnum),
        .rs_num     (rs_num),
        .rt_num     (rt_num),
        .b_is_reg   (b_is_reg),
        .stall      (stall)
    );

endmodule

`default_nettype wire

// File: tests/decode_vectors.svh
    // Columns of add_stimulus are inst, pc, flush, ex_mem_read and ex_w_regnum
    // Columns of add_expect are stall, alu_op, control, mem, b_src, write_enable, lui,
    // the trap bits {syscall, break, reserved} and w_regnum
    task automatic load_vectors();
        add_stimulus(32'h0000_0000, 64'h400000, 1'b0, 1'b0, 5'd0);     // SLL r0 as a nop
        add_writeback(5'd5, 64'h0123_4567_89ab_cdef);
        add_expect(1'b0, alu_sll, ctl_none, mem_none, b_reg, 1'b1, 1'b0, 3'b000, 5'd0);
        add_stimulus(32'h0000_0000, 64'h400004, 1'b0, 1'b0, 5'd0);
        add_writeback(5'd6, 64'hfedc_ba98_7654_3210);
        add_expect(1'b0, alu_sll, ctl_none, mem_none, b_reg, 1'b1, 1'b0, 3'b000, 5'd0);
        add_stimulus(r_type(5'd5, 5'd6, 5'd7, 5'd0, fn_addu), 64'h400008, 1'b0, 1'b0, 5'd0);
        add_writeback(5'd9, 64'h0000_0000_dead_beef);
        add_expect(1'b0, alu_add, ctl_none, mem_none, b_reg, 1'b1, 1'b0, 3'b000, 5'd7);
        add_stimulus(r_type(5'd10, 5'd0, 5'd11, 5'd0, fn_addu), 64'h40000c, 1'b0, 1'b0, 5'd0);
        add_writeback(5'd10, 64'h1111_2222_3333_4444);              // Read in the same cycle
        add_expect(1'b0, alu_add, ctl_none, mem_none, b_reg, 1'b1, 1'b0, 3'b000, 5'd11);
        add_stimulus(r_type(5'd0, 5'd5, 5'd12, 5'd0, fn_or), 64'h400010, 1'b0, 1'b0, 5'd0);
        add_writeback(5'd0, 64'hffff_ffff_ffff_ffff);
        add_expect(1'b0, alu_or, ctl_none, mem_none, b_reg, 1'b1, 1'b0, 3'b000, 5'd12);

        // Immediate, memory and shift forms
        add_stimulus(i_type(op_addiu, 5'd5, 5'd6, 16'hfffd), 64'h400014, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_none, mem_none, b_sext_imm, 1'b1, 1'b0, 3'b000, 5'd6);
        add_stimulus(i_type(op_ori, 5'd9, 5'd14, 16'h8001), 64'h400018, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_or, ctl_none, mem_none, b_zext_imm, 1'b1, 1'b0, 3'b000, 5'd14);
        add_stimulus(i_type(op_lui, 5'd0, 5'd15, 16'h1234), 64'h40001c, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_or, ctl_none, mem_none, b_zext_imm, 1'b1, 1'b1, 3'b000, 5'd15);
        add_stimulus(i_type(op_ld, 5'd5, 5'd16, 16'h0008), 64'h400020, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_none, mem_load_double, b_sext_imm, 1'b1, 1'b0, 3'b000, 5'd16);
        add_stimulus(i_type(op_sd, 5'd5, 5'd6, 16'h0010), 64'h400024, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_none, mem_store_double, b_sext_imm, 1'b0, 1'b0, 3'b000, 5'd0);
        add_stimulus(r_type(5'd0, 5'd6, 5'd17, 5'd4, fn_sll), 64'h400028, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_sll, ctl_none, mem_none, b_reg, 1'b1, 1'b0, 3'b000, 5'd17);

        // Control transfers where BEQ takes w_regnum from the rd field inside the offset
        add_stimulus(j_type(op_jal, 26'h012_0040), 64'h400030, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_jump_link, mem_none, b_reg, 1'b1, 1'b0, 3'b000, 5'd31);
        add_stimulus(i_type(op_beq, 5'd5, 5'd6, 16'hfffc), 64'h400100, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_sub, ctl_branch_eq, mem_none, b_reg, 1'b0, 1'b0, 3'b000, 5'd31);
        add_stimulus(j_type(op_j, 26'h2aa_0000), 64'habcd_0000_1000_0000, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_jump, mem_none, b_reg, 1'b0, 1'b0, 3'b000, 5'd0);

        // Load-use hazards and flush
        add_stimulus(r_type(5'd5, 5'd6, 5'd18, 5'd0, fn_addu), 64'h400104, 1'b0, 1'b1, 5'd5);
        add_expect(1'b1, alu_add, ctl_none, mem_none, b_reg, 1'b1, 1'b0, 3'b000, 5'd18);
        add_stimulus(i_type(op_beq, 5'd7, 5'd6, 16'h0008), 64'h400108, 1'b0, 1'b1, 5'd6);
        add_expect(1'b1, alu_sub, ctl_branch_eq, mem_none, b_reg, 1'b0, 1'b0, 3'b000, 5'd0);
        add_stimulus(i_type(op_addiu, 5'd7, 5'd20, 16'h0001), 64'h40010c, 1'b0, 1'b1, 5'd20);
        add_expect(1'b0, alu_add, ctl_none, mem_none, b_sext_imm, 1'b1, 1'b0, 3'b000, 5'd20);
        add_stimulus(i_type(op_lui, 5'd0, 5'd21, 16'h00ff), 64'h400110, 1'b0, 1'b1, 5'd0);
        add_expect(1'b0, alu_or, ctl_none, mem_none, b_zext_imm, 1'b1, 1'b1, 3'b000, 5'd21);
        add_stimulus(i_type(op_ori, 5'd5, 5'd22, 16'h00f0), 64'h400114, 1'b1, 1'b0, 5'd0);
        add_expect(1'b0, alu_or, ctl_none, mem_none, b_zext_imm, 1'b1, 1'b0, 3'b000, 5'd22);

        // Traps and unknown encodings
        add_stimulus(r_type(5'd0, 5'd0, 5'd0, 5'd0, fn_syscall), 64'h400118, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_none, mem_none, b_reg, 1'b0, 1'b0, 3'b100, 5'd0);
        add_stimulus(r_type(5'd5, 5'd6, 5'd0, 5'd0, fn_break), 64'h40011c, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_none, mem_none, b_reg, 1'b0, 1'b0, 3'b010, 5'd0);
        add_stimulus(i_type(6'h1c, 5'd5, 5'd6, 16'h0002), 64'h400120, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_none, mem_none, b_reg, 1'b0, 1'b0, 3'b001, 5'd0);
        add_stimulus(r_type(5'd5, 5'd6, 5'd8, 5'd0, 6'h3f), 64'h400124, 1'b0, 1'b0, 5'd0);
        add_expect(1'b0, alu_add, ctl_none, mem_none, b_reg, 1'b0, 1'b0, 3'b001, 5'd8);
    endtask

// File: tests/decode_tb.sv
`default_nettype none

module decode_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_pkg::*;

    localparam int period = 20;

    logic            clock;
    logic            reset;
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
    logic            flush;
    logic            ex_mem_read;
    logic [4:0]      ex_w_regnum;
    logic            wb_write_enable;
    logic [4:0]      wb_regnum;
    logic [xlen-1:0] wb_data;

    logic            stall;
    alu_op_t         id_alu_op;
    control_type_t   id_control_type;
    mem_type_t       id_mem_type;
    alu_b_src_t      id_alu_b_src;
    logic            id_write_enable, id_lui, id_syscall, id_break, id_reserved;
    logic [4:0]      id_w_regnum, id_shamt;
    logic [xlen-1:0] id_a_data, id_b_data, id_pc, id_pc4, id_pc_branch, id_jump_addr;
    logic [31:0]     id_inst;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector table with one entry per cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [31:0]     row_inst[$];
    logic [xlen-1:0] row_pc[$];
    logic            row_flush[$];
    logic            row_ex_load[$];
    logic [4:0]      row_ex_reg[$];
    logic            row_wb_we[$];
    logic [4:0]      row_wb_reg[$];
    logic [xlen-1:0] row_wb_data[$];
    logic            want_stall[$];
    alu_op_t         want_alu[$];
    control_type_t   want_ctl[$];
    mem_type_t       want_mem[$];
    alu_b_src_t      want_b_src[$];
    logic            want_we[$];
    logic            want_lui[$];
    logic [2:0]      want_trap[$];      // Syscall, break, reserved
    logic [4:0]      want_wreg[$];
    int              row_count;

    logic [xlen-1:0] model_regs[32];    // Register contents as the testbench expects them

    decode_top #(.data_width(xlen)) i_decode_top (
        .clock(clock), .reset(reset), .inst(inst), .pc(pc), .flush(flush),
        .ex_mem_read(ex_mem_read), .ex_w_regnum(ex_w_regnum),
        .wb_write_enable(wb_write_enable), .wb_regnum(wb_regnum), .wb_data(wb_data),
        .stall(stall), .id_alu_op(id_alu_op), .id_control_type(id_control_type),
        .id_mem_type(id_mem_type), .id_alu_b_src(id_alu_b_src),
        .id_write_enable(id_write_enable), .id_lui(id_lui), .id_syscall(id_syscall),
        .id_break(id_break), .id_reserved(id_reserved), .id_w_regnum(id_w_regnum),
        .id_shamt(id_shamt), .id_a_data(id_a_data), .id_b_data(id_b_data),
        .id_inst(id_inst), .id_pc(id_pc), .id_pc4(id_pc4),
        .id_pc_branch(id_pc_branch), .id_jump_addr(id_jump_addr)
    );

    always #(period / 2) clock = ~clock;

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] fn);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic add_stimulus(input logic [31:0] w, input logic [xlen-1:0] at_pc,
                                input logic fl, input logic ex_load, input logic [4:0] ex_reg);
        row_inst.push_back(w);
        row_pc.push_back(at_pc);
        row_flush.push_back(fl);
        row_ex_load.push_back(ex_load);
        row_ex_reg.push_back(ex_reg);
        row_wb_we.push_back(1'b0);
        row_wb_reg.push_back(5'd0);
        row_wb_data.push_back('0);
    endtask

    // Adds a writeback to the row pushed last
    task automatic add_writeback(input logic [4:0] num, input logic [xlen-1:0] value);
        row_wb_we[row_wb_we.size() - 1]     = 1'b1;
        row_wb_reg[row_wb_reg.size() - 1]   = num;
        row_wb_data[row_wb_data.size() - 1] = value;
    endtask

    task automatic add_expect(input logic st, input alu_op_t alu, input control_type_t ctl,
                              input mem_type_t mem, input alu_b_src_t b_src, input logic we,
                              input logic lui, input logic [2:0] trap, input logic [4:0] wreg);
        want_stall.push_back(st);
        want_alu.push_back(alu);
        want_ctl.push_back(ctl);
        want_mem.push_back(mem);
        want_b_src.push_back(b_src);
        want_we.push_back(we);
        want_lui.push_back(lui);
        want_trap.push_back(trap);
        want_wreg.push_back(wreg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want)
            stop_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, want, got));
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] want);
        if (got !== want)
            stop_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, want, got));
    endtask

    task automatic check_regnum(input string name, input logic [4:0] got, input logic [4:0] want);
        if (got !== want)
            stop_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, want, got));
    endtask

    task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t want);
        if (got !== want)
            stop_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, want, got));
    endtask

    task automatic check_control(input string name, input control_type_t got,
                                 input control_type_t want);
        if (got !== want)
            stop_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, want, got));
    endtask

    task automatic check_mem(input string name, input mem_type_t got, input mem_type_t want);
        if (got !== want)
            stop_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, want, got));
    endtask

    task automatic check_b_src(input string name, input alu_b_src_t got, input alu_b_src_t want);
        if (got !== want)
            stop_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, want, got));
    endtask

    // Register read as seen in row k where a write in the same cycle is visible
    function automatic logic [xlen-1:0] model_read(input int k, input logic [4:0] num);
        if (num == 5'd0)
            return '0;
        if (row_wb_we[k] && row_wb_reg[k] == num)
            return row_wb_data[k];
        return model_regs[num];
    endfunction

    // A negative row number checks the reset state
    task automatic check_outputs(input int n);
        int              k;
        logic            live;
        logic [31:0]     w;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] offset;
        logic [xlen-1:0] b_val;
        k = (n < 0) ? 0 : n;
        live = (n >= 0) && !(want_stall[k] || row_flush[k]);
        w = live ? row_inst[k] : 32'h0;
        next_pc = row_pc[k] + 64'd4;
        offset = {{48{w[15]}}, w[15:0]};
        b_val = (want_trap[k] != 3'b000) ? {32'h0, w} : model_read(k, w[20:16]);
        check_word("id_pc", id_pc, (n < 0) ? '0 : row_pc[k]);
        check_alu_op("id_alu_op", id_alu_op, live ? want_alu[k] : alu_add);
        check_control("id_control_type", id_control_type, live ? want_ctl[k] : ctl_none);
        check_mem("id_mem_type", id_mem_type, live ? want_mem[k] : mem_none);
        check_b_src("id_alu_b_src", id_alu_b_src, live ? want_b_src[k] : b_reg);
        check_bit("id_write_enable", id_write_enable, live && want_we[k]);
        check_bit("id_lui", id_lui, live && want_lui[k]);
        check_bit("id_syscall", id_syscall, live && want_trap[k][2]);
        check_bit("id_break", id_break, live && want_trap[k][1]);
        check_bit("id_reserved", id_reserved, live && want_trap[k][0]);
        check_regnum("id_w_regnum", id_w_regnum, live ? want_wreg[k] : 5'd0);
        check_regnum("id_shamt", id_shamt, w[10:6]);
        check_word("id_a_data", id_a_data, live ? model_read(k, w[25:21]) : '0);
        check_word("id_b_data", id_b_data, live ? b_val : '0);
        check_word("id_inst", {32'h0, id_inst}, {32'h0, w});
        check_word("id_pc4", id_pc4, live ? next_pc : '0);
        check_word("id_pc_branch", id_pc_branch, live ? next_pc + offset * 4 : '0);
        check_word("id_jump_addr", id_jump_addr,
                   live ? {row_pc[k][63:28], w[25:0], 2'b00} : '0);
    endtask

    task automatic apply_row(input int n);
        inst            = row_inst[n];
        pc              = row_pc[n];
        flush           = row_flush[n];
        ex_mem_read     = row_ex_load[n];
        ex_w_regnum     = row_ex_reg[n];
        wb_write_enable = row_wb_we[n];
        wb_regnum       = row_wb_reg[n];
        wb_data         = row_wb_data[n];
    endtask

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        inst            = 32'h0;
        pc              = '0;
        flush           = 1'b0;
        ex_mem_read     = 1'b0;
        ex_w_regnum     = 5'd0;
        wb_write_enable = 1'b0;
        wb_regnum       = 5'd0;
        wb_data         = '0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        load_vectors();
        row_count = row_inst.size();

        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        check_outputs(-1);

        for (int n = 0; n < row_count; n++) begin
            apply_row(n);
            @(negedge clock);
            check_bit("stall", stall, want_stall[n]);   // Stall is combinational and has settled
            @(posedge clock);
            #1;
            check_outputs(n);
            if (row_wb_we[n] && row_wb_reg[n] != 5'd0)
                model_regs[row_wb_reg[n]] = row_wb_data[n];
            #1;
        end
        $display("Done: no errors");
        $finish;
    end

    // Watchdog
    initial begin
        wait (row_count > 0);
        #((row_count + 10) * period);
        $display("Timed out: the vector run did not finish in time");
        $display("Done: errors found");
        $fatal(1);
    end

`include "decode_vectors.svh"

endmodule

`default_nettype wire

// File: files.f
+incdir+tests
verilog/mips_pkg.sv
verilog/mips_decoder.sv
verilog/regfile.sv
verilog/load_use_hazard.sv
verilog/decode_stage.sv
verilog/decode_top.sv
tests/decode_tb.sv
